//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module aluPipeTb -f vlog.f -o simv \
	|| { echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -qF '*** FAILED ***' sim.log && { echo "simulation reported a failure"; exit 1; }
grep -qF '*** PASSED ***' sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

//--- source/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import aluPkg::*, isaPkg::*; (
	input logic clk,
	input logic rst,
	input logic decValid,
	input execReq decOut,
	output logic wbValid,
	output wbResult wbOut
);

	logic [dataWidth-1:0] a;
	logic [dataWidth-1:0] b;
	logic [dataWidth:0] sum;    // carry in top bit
	logic [dataWidth:0] diff;   // top bit high means no borrow
	logic [dataWidth-1:0] srlVal;
	logic [dataWidth-1:0] sllVal;
	logic [dataWidth-1:0] sraVal;
	logic [dataWidth-1:0] slaVal;
	logic [dataWidth-1:0] value;
	aluFlags flags;

	assign a = decOut.a;
	assign b = decOut.b;
	assign sum = {1'b0, a} + {1'b0, b} + {{dataWidth{1'b0}}, decOut.cin};
	assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1;   // two's complement subtract

	shiftUnit shifter (
		.a(a),
		.amount(b[2:0]),
		.srl(srlVal),
		.sll(sllVal),
		.sra(sraVal),
		.sla(slaVal)
	);

	always_comb begin
		value = '0;
		flags = '0;
		case (decOut.op)
			opAdd: begin
				value = sum[dataWidth-1:0];
				flags.cout = sum[dataWidth];
				flags.overflow = (a[dataWidth-1] == b[dataWidth-1]) &&
					(value[dataWidth-1] != a[dataWidth-1]);
			end
			opSub: begin
				value = diff[dataWidth-1:0];
				flags.cout = diff[dataWidth];
				flags.overflow = (a[dataWidth-1] != b[dataWidth-1]) &&
					(value[dataWidth-1] != a[dataWidth-1]);
			end
			opNot: value = ~a;
			opAnd: value = a & b;
			opOr:  value = a | b;
			opXor: value = a ^ b;
			opSrl: value = srlVal;
			opSll: value = sllVal;
			opSra: value = sraVal;
			opSla: value = slaVal;
			default: value = '0;   // invalid code
		endcase
		flags.neg = value[dataWidth-1];
		flags.zero = (value == '0);
	end

	always_ff @(posedge clk) begin
		if (rst)
			wbValid <= 1'b0;
		else
			wbValid <= decValid;
	end

	always_ff @(posedge clk) begin
		if (decValid) begin
			wbOut.rd <= decOut.rd;
			wbOut.value <= value;
			wbOut.flags <= flags;
		end
	end

	// no forwarding, so a decode waits until the last writeback has landed
	decSpaced: assert property (@(posedge clk) disable iff (rst)
		decValid |-> !$past(decValid) && !$past(decValid, 2));

endmodule

`default_nettype wire

//--- source/aluPipeTop.sv
`timescale 1ns/100ps
`default_nettype none

module aluPipeTop import aluPkg::*, isaPkg::*; (
	input logic clk,
	input logic rst,
	input logic instrReq,
	input instrWord instr,
	output logic instrAck,
	output logic resultValid,
	output wbResult result
);

	regIdx rdAddrA;
	regIdx rdAddrB;
	logic [dataWidth-1:0] rdDataA;
	logic [dataWidth-1:0] rdDataB;
	logic decValid;
	execReq decOut;

	instrIntake intake (
		.clk(clk),
		.rst(rst),
		.instrReq(instrReq),
		.instr(instr),
		.instrAck(instrAck),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.decValid(decValid),
		.decOut(decOut)
	);

	// writeback port fed straight from the result register
	regFile regs (
		.clk(clk),
		.rst(rst),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.wrEn(resultValid),
		.wrIdx(result.rd),
		.wrData(result.value)
	);

	alu exec (
		.clk(clk),
		.rst(rst),
		.decValid(decValid),
		.decOut(decOut),
		.wbValid(resultValid),
		.wbOut(result)
	);

endmodule

`default_nettype wire

//--- source/aluPkg.sv
`default_nettype none

package aluPkg;

	localparam int dataWidth = 8;   // register and operand width
	localparam int opWidth = 4;

	// codes 10 to 15 are invalid and give a zero result
	typedef enum logic [opWidth-1:0] {
		opAdd = 4'd0,
		opSub = 4'd1,
		opNot = 4'd2,
		opAnd = 4'd3,
		opOr  = 4'd4,
		opXor = 4'd5,
		opSrl = 4'd6,
		opSll = 4'd7,
		opSra = 4'd8,
		opSla = 4'd9
	} aluOp;

	typedef struct packed {
		logic neg;
		logic zero;
		logic cout;       // carry out, or no-borrow on sub
		logic overflow;   // signed overflow, add and sub only
	} aluFlags;

endpackage

`default_nettype wire

//--- source/instrIntake.sv
`timescale 1ns/100ps
`default_nettype none

module instrIntake import aluPkg::*, isaPkg::*; (
	input logic clk,
	input logic rst,
	input logic instrReq,
	input instrWord instr,
	output logic instrAck,
	output regIdx rdAddrA,
	output regIdx rdAddrB,
	input logic [dataWidth-1:0] rdDataA,
	input logic [dataWidth-1:0] rdDataB,
	output logic decValid,
	output execReq decOut
);

	typedef enum logic [1:0] {
		sIdle,
		sDecode,
		sAck
	} intakeState;

	intakeState state;
	instrWord held;                  // captured word
	logic [dataWidth-1:0] immExt;
	logic [dataWidth-1:0] operandB;

	// rs1 sits at the same place in both formats
	assign rdAddrA = held.regFmt.rs1;
	assign rdAddrB = held.regFmt.rs2;
	assign immExt = {{(dataWidth-immWidth){held.immFmt.imm5[immWidth-1]}}, held.immFmt.imm5};
	assign operandB = held.immFmt.immForm ? immExt : rdDataB;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sIdle;
			instrAck <= 1'b0;
			decValid <= 1'b0;
		end else begin
			decValid <= 1'b0;   // single cycle pulse
			case (state)
				sIdle: begin
					if (instrReq)
						state <= sDecode;
				end
				sDecode: begin
					instrAck <= 1'b1;
					decValid <= 1'b1;
					state <= sAck;
				end
				sAck: begin
					if (!instrReq) begin   // sender released, close the handshake
						instrAck <= 1'b0;
						state <= sIdle;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == sIdle && instrReq)
			held <= instr;
		if (state == sDecode) begin
			decOut.op <= held.regFmt.op;
			decOut.rd <= held.regFmt.rd;
			decOut.a <= rdDataA;
			decOut.b <= operandB;
			decOut.cin <= held.immFmt.immForm ? 1'b0 : held.regFmt.cin;
		end
	end

	// ack only answers a request that was already up
	ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
		$rose(instrAck) |-> $past(instrReq));

endmodule

`default_nettype wire

//--- source/isaPkg.sv
`default_nettype none

package isaPkg;

	import aluPkg::*;

	localparam int regCount = 8;
	localparam int immWidth = 5;

	typedef logic [$clog2(regCount)-1:0] regIdx;

	typedef struct packed {
		logic immForm;   // low in this format
		aluOp op;
		regIdx rd;
		regIdx rs1;
		regIdx rs2;
		logic cin;
		logic spare;
	} regFields;

	typedef struct packed {
		logic immForm;   // high in this format
		aluOp op;
		regIdx rd;
		regIdx rs1;
		logic [immWidth-1:0] imm5;   // sign extended, cin forced to 0
	} immFields;

	// one 16-bit word, read either way depending on immForm
	typedef union packed {
		regFields regFmt;
		immFields immFmt;
	} instrWord;

	typedef struct packed {
		aluOp op;
		regIdx rd;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic cin;
	} execReq;

	typedef struct packed {
		regIdx rd;
		logic [dataWidth-1:0] value;
		aluFlags flags;
	} wbResult;

endpackage

`default_nettype wire

//--- source/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile import aluPkg::*, isaPkg::*; (
	input logic clk,
	input logic rst,
	input regIdx rdAddrA,
	input regIdx rdAddrB,
	output logic [dataWidth-1:0] rdDataA,
	output logic [dataWidth-1:0] rdDataB,
	input logic wrEn,
	input regIdx wrIdx,
	input logic [dataWidth-1:0] wrData
);

	logic [dataWidth-1:0] regs [regCount];

	// r0 is never written, so it keeps its reset value of zero
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrIdx != '0) begin   // drop writes to r0
			regs[wrIdx] <= wrData;
		end
	end

endmodule

`default_nettype wire

//--- source/shiftUnit.sv
`timescale 1ns/100ps
`default_nettype none

module shiftUnit import aluPkg::*; (
	input logic [dataWidth-1:0] a,
	input logic [2:0] amount,
	output logic [dataWidth-1:0] srl,
	output logic [dataWidth-1:0] sll,
	output logic [dataWidth-1:0] sra,
	output logic [dataWidth-1:0] sla
);

	assign srl = a >> amount;             // zero fill
	assign sll = a << amount;
	assign sra = $signed(a) >>> amount;   // sign fill

	// same as sll but the sign bit stays put
	assign sla = {a[dataWidth-1], sll[dataWidth-2:0]};

endmodule

`default_nettype wire

//--- include/aluModel.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

logic [dataWidth-1:0] modelRegs [8];

function automatic void modelWrite(input regIdx rd, input logic [dataWidth-1:0] v);
	if (rd != 0)   // r0 stays zero
		modelRegs[rd] = v;
endfunction

// expected writeback for one instruction against the current model registers
function automatic wbResult refResult(input instrWord w);
	wbResult r;
	logic [dataWidth-1:0] a;
	logic [dataWidth-1:0] b;
	logic [dataWidth-1:0] v;
	logic cin;
	int sa;
	int sb;
	int full;
	int sh;
	a = modelRegs[w.regFmt.rs1];
	b = modelRegs[w.regFmt.rs2];
	cin = w.regFmt.cin;
	if (w.immFmt.immForm) begin
		full = $signed(w.immFmt.imm5);   // sign extend imm5
		b = full[dataWidth-1:0];
		cin = 1'b0;
	end
	sa = $signed(a);
	sb = $signed(b);
	sh = b[2:0];
	r = '0;
	v = '0;
	r.rd = w.regFmt.rd;
	case (w.regFmt.op)
		opAdd: begin
			full = a + b + cin;
			v = full[dataWidth-1:0];
			r.flags.cout = full > 255;
			full = sa + sb + int'(cin);
			r.flags.overflow = full > 127 || full < -128;
		end
		opSub: begin
			full = a - b;
			v = full[dataWidth-1:0];
			r.flags.cout = a >= b;   // no borrow
			full = sa - sb;
			r.flags.overflow = full > 127 || full < -128;
		end
		opNot: v = ~a;
		opAnd: v = a & b;
		opOr: v = a | b;
		opXor: v = a ^ b;
		opSrl: v = a >> sh;
		opSll: v = a << sh;
		opSra: begin
			full = sa >>> sh;
			v = full[dataWidth-1:0];
		end
		opSla: begin
			v = a << sh;
			v[dataWidth-1] = a[dataWidth-1];   // sign bit kept
		end
		default: v = '0;
	endcase
	r.value = v;
	r.flags.neg = v[dataWidth-1];
	r.flags.zero = (v == 0);
	return r;
endfunction

`endif

//--- tb/aluPipeTb.sv
`timescale 1ns/100ps
`default_nettype none

module aluPipeTb import aluPkg::*, isaPkg::*; ();

	localparam int timeoutCycles = 300 * 12 + 100;

	logic clk = 1'b0;
	logic rst;
	logic instrReq;
	instrWord instr;
	logic instrAck;
	logic resultValid;
	wbResult result;

	logic [15:0] lfsrState = 16'd26;
	int cycleCount = 0;
	int sentCount = 0;
	int doneCount = 0;
	instrWord pendInstr [$];   // instructions waiting for their result
	int pendCycle [$];
	wbResult expected;

	`include "aluModel.svh"

	aluPipeTop uut (
		.clk(clk),
		.rst(rst),
		.instrReq(instrReq),
		.instr(instr),
		.instrAck(instrAck),
		.resultValid(resultValid),
		.result(result)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Error at %0t: the test did not finish within %0d cycles", $time, cycleCount);
			$display("*** FAILED ***");
			$fatal(1, "timeout");
		end
	end

	task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "first mismatch");
		end
	endtask

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11
	endfunction

	task automatic takeBits(input int n, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[14:0], lfsrState[15]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	function automatic instrWord regInstr(input logic [3:0] op, input regIdx rd,
			input regIdx rs1, input regIdx rs2, input logic cin);
		instrWord w;
		w.regFmt = '{immForm: 1'b0, op: aluOp'(op), rd: rd, rs1: rs1, rs2: rs2,
			cin: cin, spare: 1'b0};
		return w;
	endfunction

	function automatic instrWord immInstr(input logic [3:0] op, input regIdx rd,
			input regIdx rs1, input logic [4:0] imm);
		instrWord w;
		w.immFmt = '{immForm: 1'b1, op: aluOp'(op), rd: rd, rs1: rs1, imm5: imm};
		return w;
	endfunction

	// four-phase send, result expected 2 cycles after the capture edge
	task automatic sendInstr(input instrWord w);
		@(posedge clk);
		#1;
		pendInstr.push_back(w);
		pendCycle.push_back(cycleCount + 3);
		instr = w;
		instrReq = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!instrAck);
		instrReq = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (instrAck);
		sentCount++;
	endtask

	task automatic loadReg(input regIdx r, input logic [7:0] v);
		sendInstr(immInstr(opAdd, r, 3'd0, {v[7], v[7:4]}));
		sendInstr(immInstr(opSll, r, r, 5'd4));
		sendInstr(immInstr(opOr, r, r, {1'b0, v[3:0]}));
	endtask

	task automatic checkIdle();
		repeat (10) begin
			@(negedge clk);
			checkEq(32'(resultValid), 32'd0, "resultValid with no request");
			checkEq(32'(instrAck), 32'd0, "instrAck with no request");
		end
	endtask

	task automatic loadConstants();
		for (int r = 1; r < 8; r++)
			sendInstr(immInstr(opAdd, regIdx'(r), 3'd0, 5'(r * 5 - 17)));
	endtask

	task automatic addSubTests();
		logic [15:0] bits;
		loadReg(3'd1, 8'h7f);
		loadReg(3'd2, 8'h01);
		loadReg(3'd3, 8'h80);
		sendInstr(regInstr(opAdd, 3'd4, 3'd1, 3'd2, 1'b0));   // positive overflow
		sendInstr(regInstr(opAdd, 3'd4, 3'd3, 3'd3, 1'b0));   // carry, zero, overflow
		sendInstr(regInstr(opSub, 3'd4, 3'd3, 3'd2, 1'b0));
		sendInstr(regInstr(opSub, 3'd4, 3'd2, 3'd2, 1'b0));
		sendInstr(regInstr(opAdd, 3'd4, 3'd1, 3'd0, 1'b1));   // cin alone overflows
		repeat (2) begin
			for (int r = 1; r < 8; r++) begin
				takeBits(8, bits);
				loadReg(regIdx'(r), bits[7:0]);
			end
			repeat (16) begin
				takeBits(11, bits);
				sendInstr(regInstr(bits[10] ? opSub : opAdd, bits[9:7], bits[6:4],
					bits[3:1], bits[0]));
			end
		end
	endtask

	task automatic logicShiftTests();
		logic [15:0] bits;
		for (int op = 2; op < 6; op++) begin
			repeat (4) begin
				takeBits(9, bits);
				sendInstr(regInstr(4'(op), bits[8:6], bits[5:3], bits[2:0], 1'b0));
			end
		end
		loadReg(3'd5, 8'ha5);
		loadReg(3'd6, 8'h3c);
		loadReg(3'd4, 8'hfb);
		for (int op = 6; op < 10; op++) begin
			for (int amt = 0; amt < 8; amt++)
				sendInstr(immInstr(4'(op), 3'd7, amt[0] ? 3'd5 : 3'd6, 5'(amt)));
			sendInstr(regInstr(4'(op), 3'd7, 3'd5, 3'd4, 1'b0));   // amount from low bits
		end
	endtask

	task automatic r0Tests();
		sendInstr(immInstr(opAdd, 3'd0, 3'd5, 5'd9));   // dropped write
		sendInstr(regInstr(opOr, 3'd1, 3'd0, 3'd0, 1'b0));
		sendInstr(regInstr(opAdd, 3'd2, 3'd0, 3'd6, 1'b0));
	endtask

	task automatic invalidOpTests();
		logic [15:0] bits;
		for (int op = 10; op < 16; op++) begin
			takeBits(9, bits);
			sendInstr(regInstr(4'(op), bits[8:6], bits[5:3], bits[2:0], 1'b1));
		end
	endtask

	task automatic randomProgram(input int n);
		logic [15:0] bits;
		instrWord w;
		repeat (n) begin
			takeBits(16, bits);
			w = bits;
			sendInstr(w);
		end
	endtask

	always @(negedge clk) begin
		if (!rst && resultValid) begin
			checkEq(32'(pendInstr.size()), 32'd1, "instructions in flight at a result");
			expected = refResult(pendInstr.pop_front());
			checkEq(cycleCount, pendCycle.pop_front(), "cycle of resultValid");
			checkEq(32'(result), 32'(expected), "result {rd, value, flags}");
			modelWrite(expected.rd, expected.value);
			doneCount++;
		end
	end

	initial begin
		rst = 1'b1;
		instrReq = 1'b0;
		instr = '0;
		for (int i = 0; i < 8; i++)
			modelRegs[i] = '0;
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
		checkIdle();
		loadConstants();
		addSubTests();
		logicShiftTests();
		r0Tests();
		invalidOpTests();
		randomProgram(300);
		while (pendInstr.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);
		checkEq(doneCount, sentCount, "number of results");
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
source/aluPkg.sv
source/isaPkg.sv
source/shiftUnit.sv
source/regFile.sv
source/instrIntake.sv
source/alu.sv
source/aluPipeTop.sv
tb/aluPipeTb.sv
